/* run.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps --top-module tb_rp_top \
  -f sim.f -o tb_rp_top \
  && ./obj_dir/tb_rp_top 2>&1 | tee /dev/stderr | grep -q "^Test passed$" \
  && echo "run ok" \
  || { echo "run FAILED"; exit 1; }

/* sim.f */
source/rp_pkg.sv
source/adc_front.sv
source/hk_regs.sv
source/spi_ctrl_fsm.sv
source/spi_bit_timer.sv
source/spi_shifter.sv
source/rp_top.sv
sim/rp_top_assert.sv
sim/tb_rp_top.sv

/* sim/rp_top_assert.sv */
// bound into rp_top; testbench touches only the tap of lane 0 on channel a, other taps stay 0
module rp_top_assert
  import rp_pkg::*;
#(
  parameter int TAP_CW = 3
)(
  input logic                      clk_250,
  input logic                      arst_n_i,
  input logic [ADC_LANES-1:0][1:0] adc_a_lane_i,
  input logic [ADC_LANES-1:0][1:0] adc_b_lane_i,
  input logic [ADC_OUT_BITS-1:0]   adc_a_o,
  input logic [ADC_OUT_BITS-1:0]   adc_b_o,
  input logic [TAP_CW-1:0]         tap_cnt_a0,
  input logic                      spi_start,
  input logic                      spi_sel,
  input logic [1:0]                spi_cs_n_o,
  input logic                      spi_clk_o
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // adc path
  ////////////////////////////////////////////////////////////////////////////

  // converter b lands on channel a, 3 cycles
  a_adc_a: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    adc_a_o == {$past(adc_b_lane_i, 3), 2'b00})
    else $error("adc_a_o does not follow the b lanes");

  a_adc_b_hi: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    {adc_b_o[15:4], adc_b_o[1:0]} == {$past(adc_a_lane_i[6:1], 3), 2'b00})
    else $error("adc_b_o upper lanes or padding wrong");

  // tap is applied two stages before the output
  a_lane0_tap0: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    $past(tap_cnt_a0, 2) == '0 |-> adc_b_o[3:2] == $past(adc_a_lane_i[0], 3))
    else $error("lane a0 latency wrong at tap 0");

  a_lane0_tap2: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    $past(tap_cnt_a0, 2) == TAP_CW'(2) |-> adc_b_o[3:2] == $past(adc_a_lane_i[0], 5))
    else $error("lane a0 latency wrong at tap 2");

  ////////////////////////////////////////////////////////////////////////////
  // spi
  ////////////////////////////////////////////////////////////////////////////

  // target 0 pulls cs 0 low and leaves cs 1 high, target 1 the other way
  a_cs_target: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    $past(spi_start) |-> spi_cs_n_o == {!$past(spi_sel), $past(spi_sel)})
    else $error("chip select does not match the target");

  a_clk_idle: assert property (@(posedge clk_250) disable iff (!arst_n_i)
    spi_cs_n_o == 2'b11 |-> !spi_clk_o)
    else $error("spi clock active without chip select");

endmodule

bind rp_top rp_top_assert #(.TAP_CW (TAP_CW)) i_rp_top_assert (
  .clk_250      (clk_250),
  .arst_n_i     (arst_n_i),
  .adc_a_lane_i (adc_a_lane_i),
  .adc_b_lane_i (adc_b_lane_i),
  .adc_a_o      (adc_a_o),
  .adc_b_o      (adc_b_o),
  .tap_cnt_a0   (tap_cnt_a0),
  .spi_start    (spi_start),
  .spi_sel      (spi_sel),
  .spi_cs_n_o   (spi_cs_n_o),
  .spi_clk_o    (spi_clk_o)
);

/* sim/tb_rp_top.sv */
// register, adc path and spi checks on rp_top with default parameters; assertions live in the bound module
module tb_rp_top
  import rp_pkg::*;
;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int       SPI_CYC  = 2 * 4 * (SPI_WORD_BITS + 2) + 8;  // one transfer plus polling
  localparam int       TEST_CYC = 10 + 100 + 100 + 4 * SPI_CYC;      // reset, regs, taps, 4 transfers
  localparam logic [7:0] SLV_BYTE = 8'hC3;     // slave answer on reads

  logic                      clk_250 = 1'b0;
  logic                      arst_n_i;
  logic [ADC_LANES-1:0][1:0] adc_a_lane_i, adc_b_lane_i;
  logic [ADC_OUT_BITS-1:0]   adc_a_o, adc_b_o;
  logic                      psel_i, penable_i, pwrite_i;
  logic [APB_AW-1:0]         paddr_i;
  logic [APB_DW-1:0]         pwdata_i, prdata_o;
  logic                      pready_o, pslverr_o;
  logic [LED_BITS-1:0]       led_o;
  logic [EXP_BITS-1:0]       exp_i, exp_o, exp_oe_o;
  logic [1:0]                spi_cs_n_o;
  logic                      spi_clk_o, spi_sdio_i, spi_sdio_o, spi_sdio_oe_o;

  logic [31:0] lfsr = 32'h6788;
  logic [31:0] rd, word;
  logic        err;
  int          stalls;
  // slave model state
  logic [15:0] slv_word = '0;
  logic        slv_read = 1'b0;
  int          slv_cnt  = 0;
  logic        sclk_q   = 1'b0;
  logic [1:0]  cs_q     = 2'b11;
  logic        sdio_nxt = 1'b0;
  logic [31:0] slv_q[$];  // {cs_n, word} per transfer

  rp_top i_dut (.*);

  initial
  begin
    forever #4 clk_250 = ~clk_250;  // 8 ns
  end

  // 32 bit fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act)
    begin
      $display("ERR %s expected %h actual %h", name, exp, act);
      $display("Test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // apb master
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output int n_wait);
    @(posedge clk_250);
    #1;
    psel_i    = 1'b1;
    pwrite_i  = 1'b1;
    paddr_i   = addr;
    pwdata_i  = data;
    penable_i = 1'b0;
    @(posedge clk_250);
    #1 penable_i = 1'b1;
    n_wait = 0;
    @(posedge clk_250);
    while (!pready_o)
    begin
      n_wait++;  // held back by a busy spi
      @(posedge clk_250);
    end
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic slverr);
    @(posedge clk_250);
    #1;
    psel_i    = 1'b1;
    pwrite_i  = 1'b0;
    paddr_i   = addr;
    penable_i = 1'b0;
    @(posedge clk_250);
    #1 penable_i = 1'b1;
    @(posedge clk_250);
    while (!pready_o)
      @(posedge clk_250);
    data   = prdata_o;   // sampled on the completing edge
    slverr = pslverr_o;
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
  endtask

  task automatic wait_spi_idle();
    do
      apb_read(REG_SPI_STAT, rd, err);
    while (rd[31]);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // adc lanes and spi slave
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    adc_a_lane_i = '0;
    adc_b_lane_i = '0;
    forever
    begin
      @(posedge clk_250);
      #1;
      for (int i = 0; i < 2 * ADC_LANES; i++)
      begin
        lfsr                    = lfsr_next(lfsr);  // one step per bit
        adc_a_lane_i[i/2][i%2] = lfsr[0];
      end
      for (int i = 0; i < 2 * ADC_LANES; i++)
      begin
        lfsr                    = lfsr_next(lfsr);
        adc_b_lane_i[i/2][i%2] = lfsr[0];
      end
    end
  end

  always @(posedge clk_250)
  begin
    if (spi_cs_n_o != 2'b11)
    begin
      if (spi_clk_o && !sclk_q)
      begin
        check("sdio_oe", 32'(!(slv_read && slv_cnt >= 8)), 32'(spi_sdio_oe_o));
        slv_word = {slv_word[14:0], spi_sdio_o};
        if (slv_cnt == 0)
          slv_read = spi_sdio_o;  // msb flags a read
        slv_cnt++;
      end
      if (!spi_clk_o && sclk_q && slv_read && slv_cnt >= 8 && slv_cnt < 16)
        sdio_nxt = SLV_BYTE[15-slv_cnt];  // answer after the turnaround
    end
    if (spi_cs_n_o == 2'b11 && cs_q != 2'b11)
    begin
      slv_q.push_back(32'({cs_q, slv_word}));  // transfer finished
      slv_cnt  = 0;
      slv_read = 1'b0;
    end
    sclk_q = spi_clk_o;
    cs_q   = spi_cs_n_o;
    #1 spi_sdio_i = sdio_nxt;
  end

  initial
  begin
    #(TEST_CYC * 8 * 2);
    $display("Test failed");
    $fatal(1, "watchdog expired before the tests finished");
  end

  ////////////////////////////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    arst_n_i  = 1'b0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    paddr_i   = '0;
    pwdata_i  = '0;
    exp_i     = '0;
    spi_sdio_i = 1'b0;
    repeat (10) @(posedge clk_250);
    #1 arst_n_i = 1'b1;
    check("cs_rst", 32'h3, 32'(spi_cs_n_o));
    check("sclk_rst", 32'd0, 32'(spi_clk_o));
    check("sdio_oe_rst", 32'd0, 32'(spi_sdio_oe_o));
    check("exp_oe_rst", 32'd0, 32'(exp_oe_o));
    check("led_rst", 32'd0, 32'(led_o));

    apb_read(REG_ID, rd, err);
    check("id", RP_ID, rd);
    check("id_err", 32'd0, 32'(err));
    apb_write(REG_LED, 32'hA5, stalls);
    apb_read(REG_LED, rd, err);
    check("led_rd", 32'hA5, rd);
    check("led_pin", 32'hA5, 32'(led_o));
    apb_write(REG_EXP_DIR, 32'h1F3, stalls);
    apb_write(REG_EXP_OUT, 32'h0AC, stalls);
    apb_read(REG_EXP_DIR, rd, err);
    check("exp_dir_rd", 32'h1F3, rd);
    apb_read(REG_EXP_OUT, rd, err);
    check("exp_out_rd", 32'h0AC, rd);
    check("exp_oe_pin", 32'h1F3, 32'(exp_oe_o));
    check("exp_pin", 32'h0AC, 32'(exp_o));
    exp_i = 9'h15A;
    repeat (3) @(posedge clk_250);
    apb_read(REG_EXP_IN, rd, err);
    check("exp_in", 32'h15A, rd);

    repeat (40) @(posedge clk_250);  // zero tap path under assertion

    apb_write(REG_TAP_INC, 32'h1, stalls);
    apb_write(REG_TAP_INC, 32'h1, stalls);
    apb_read(REG_TAP_CNT, rd, err);
    check("tap_inc", 32'h2, rd);
    repeat (40) @(posedge clk_250);  // lane a0 now 5 cycles behind
    apb_write(REG_TAP_RST, 32'h1, stalls);
    apb_read(REG_TAP_CNT, rd, err);
    check("tap_rst", 32'h0, rd);
    apb_write(REG_TAP_DEC, 32'h1, stalls);
    apb_read(REG_TAP_CNT, rd, err);
    check("tap_dec_sat", 32'h0, rd);

    apb_write(REG_SPI_CMD, 32'h0000_2A5C, stalls);  // adc write
    wait_spi_idle();
    check("spi_wr_count", 32'd1, 32'(slv_q.size()));
    word = slv_q.pop_front();
    check("spi_wr_word", 32'h0002_2A5C, word);  // cs 0 low, cs 1 high

    apb_write(REG_SPI_CMD, 32'h0001_9B00, stalls);  // dac read
    wait_spi_idle();
    check("spi_rd_byte", 32'(SLV_BYTE), rd);
    word = slv_q.pop_front();
    check("spi_rd_addr", 32'h19B, 32'(word[17:8]));  // cs 1 low

    apb_write(REG_SPI_CMD, 32'h0000_1234, stalls);
    apb_write(REG_SPI_CMD, 32'h0000_4321, stalls);  // lands while busy
    check("spi_stall", 32'd1, 32'(stalls > 0));
    wait_spi_idle();
    check("spi_bp_count", 32'd2, 32'(slv_q.size()));
    word = slv_q.pop_front();
    check("spi_bp_first", 32'h0002_1234, word);
    word = slv_q.pop_front();
    check("spi_bp_second", 32'h0002_4321, word);

    apb_read(8'h40, rd, err);
    check("unmapped_err", 32'd1, 32'(err));
    check("unmapped_data", 32'd0, rd);

    $display("Test passed");
    $finish;
  end

endmodule

/* source/adc_front.sv */
// lane delay is whole clk_250 cycles up to TAP_DEPTH-1 (TAP_DEPTH 2..16); latency is 3 + tap cycles
module adc_front
  import rp_pkg::*;
#(
  parameter  int TAP_DEPTH = 8,
  localparam int TAP_CW    = $clog2(TAP_DEPTH)
)(
  input  logic                      clk_250,
  input  logic                      arst_n_i,
  input  logic [ADC_LANES-1:0][1:0] adc_a_lane_i,
  input  logic [ADC_LANES-1:0][1:0] adc_b_lane_i,
  input  logic [2*ADC_LANES-1:0]    tap_rst_i,     // lanes 0..6 a, 7..13 b
  input  logic [2*ADC_LANES-1:0]    tap_inc_i,
  input  logic [2*ADC_LANES-1:0]    tap_dec_i,
  output logic [ADC_OUT_BITS-1:0]   adc_a_o,
  output logic [ADC_OUT_BITS-1:0]   adc_b_o,
  output logic [TAP_CW-1:0]         tap_cnt_a0_o,
  output logic [TAP_CW-1:0]         tap_cnt_b0_o
);

  localparam int NL = 2 * ADC_LANES;  // both converters, same order as tap masks

  logic [NL-1:0][1:0]                lane_in;   // a lanes low, b lanes high
  logic [NL-1:0][TAP_DEPTH-1:0][1:0] hist;      // [0] is the input register
  logic [NL-1:0][TAP_CW-1:0]         tap_cnt;
  logic [NL-1:0][1:0]                lane_dly;  // selected pair per lane
  logic [ADC_BITS-1:0]               samp_a, samp_b;
  logic [ADC_OUT_BITS-1:0]           sw_a_r, sw_b_r;

  assign lane_in = {adc_b_lane_i, adc_a_lane_i};

  ////////////////////////////////////////////////////////////////////////////
  // per lane history and tap select
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250)
  begin
    for (int l = 0; l < NL; l++)
    begin
      hist[l] <= {hist[l][TAP_DEPTH-2:0], lane_in[l]};  // age by one cycle
    end
  end

  // saturating tap counters, reset wins over inc/dec
  always_ff @(posedge clk_250 or negedge arst_n_i)
  begin
    if (!arst_n_i)
      tap_cnt <= '0;
    else
    begin
      for (int l = 0; l < NL; l++)
      begin
        if (tap_rst_i[l])
          tap_cnt[l] <= '0;
        else if (tap_inc_i[l] && tap_cnt[l] != TAP_CW'(TAP_DEPTH-1))
          tap_cnt[l] <= tap_cnt[l] + 1'b1;
        else if (tap_dec_i[l] && tap_cnt[l] != '0)
          tap_cnt[l] <= tap_cnt[l] - 1'b1;
      end
    end
  end

  always_comb
  begin
    for (int l = 0; l < NL; l++)
    begin
      lane_dly[l] = hist[l][tap_cnt[l]];
    end
  end

  // lane n lands on bits 2n+1:2n
  assign samp_a = lane_dly[ADC_LANES-1:0];
  assign samp_b = lane_dly[NL-1:ADC_LANES];

  ////////////////////////////////////////////////////////////////////////////
  // channel swap and lsb padding, two stages
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250)
  begin
    sw_a_r  <= {samp_b, {(ADC_OUT_BITS-ADC_BITS){1'b0}}};  // conv b -> ch a
    sw_b_r  <= {samp_a, {(ADC_OUT_BITS-ADC_BITS){1'b0}}};  // conv a -> ch b
    adc_a_o <= sw_a_r;
    adc_b_o <= sw_b_r;
  end

  assign tap_cnt_a0_o = tap_cnt[0];
  assign tap_cnt_b0_o = tap_cnt[ADC_LANES];  // lane 0 of b

endmodule

/* source/hk_regs.sv */
// apb slave, zero wait states except an spi command write while busy; unmapped addresses raise pslverr
module hk_regs
  import rp_pkg::*;
#(
  parameter  int TAP_DEPTH = 8,
  localparam int TAP_CW    = $clog2(TAP_DEPTH)
)(
  input  logic                                    clk_250,
  input  logic                                    arst_n_i,
  input  logic                                    psel_i,
  input  logic                                    penable_i,
  input  logic                                    pwrite_i,
  input  logic [APB_AW-1:0]                       paddr_i,
  input  logic [APB_DW-1:0]                       pwdata_i,
  output logic [APB_DW-1:0]                       prdata_o,
  output logic                                    pready_o,
  output logic                                    pslverr_o,
  input  logic [EXP_BITS-1:0]                     exp_i,
  output logic [LED_BITS-1:0]                     led_o,
  output logic [EXP_BITS-1:0]                     exp_o,
  output logic [EXP_BITS-1:0]                     exp_oe_o,
  input  logic [TAP_CW-1:0]                       tap_cnt_a0_i,
  input  logic [TAP_CW-1:0]                       tap_cnt_b0_i,
  output logic [2*ADC_LANES-1:0]                  tap_rst_o,    // one cycle pulses
  output logic [2*ADC_LANES-1:0]                  tap_inc_o,
  output logic [2*ADC_LANES-1:0]                  tap_dec_o,
  input  logic                                    spi_busy_i,
  input  logic [SPI_WORD_BITS-SPI_READ_SPLIT-1:0] spi_rx_i,
  output logic                                    spi_start_o,
  output logic [SPI_WORD_BITS-1:0]                spi_word_o,
  output logic                                    spi_sel_o     // 0 adc, 1 dac
);

  reg_addr_e           addr;
  logic                access;          // apb access phase
  logic                wr_en;           // write completes this cycle
  logic [EXP_BITS-1:0] exp_s1, exp_s2;  // pin synchronizer

  assign addr     = reg_addr_e'(paddr_i);
  assign access   = psel_i & penable_i;
  // the one stall: spi command while a transfer runs
  assign pready_o = ~(pwrite_i & (addr == REG_SPI_CMD) & spi_busy_i);
  assign wr_en    = access & pwrite_i & pready_o;

  ////////////////////////////////////////////////////////////////////////////
  // writable registers and command pulses
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_250 or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      led_o     <= '0;
      exp_o     <= '0;
      exp_oe_o  <= '0;  // all pins input
      tap_rst_o <= '0;
      tap_inc_o <= '0;
      tap_dec_o <= '0;
      exp_s1    <= '0;
      exp_s2    <= '0;
    end
    else
    begin
      if (wr_en && addr == REG_LED)     led_o    <= pwdata_i[LED_BITS-1:0];
      if (wr_en && addr == REG_EXP_DIR) exp_oe_o <= pwdata_i[EXP_BITS-1:0];
      if (wr_en && addr == REG_EXP_OUT) exp_o    <= pwdata_i[EXP_BITS-1:0];
      // masks drop back to zero next cycle
      tap_rst_o <= (wr_en && addr == REG_TAP_RST) ? pwdata_i[2*ADC_LANES-1:0] : '0;
      tap_inc_o <= (wr_en && addr == REG_TAP_INC) ? pwdata_i[2*ADC_LANES-1:0] : '0;
      tap_dec_o <= (wr_en && addr == REG_TAP_DEC) ? pwdata_i[2*ADC_LANES-1:0] : '0;
      exp_s1    <= exp_i;
      exp_s2    <= exp_s1;
    end
  end

  // spi launch, fsm latches what it needs on this cycle
  assign spi_start_o = wr_en & (addr == REG_SPI_CMD);
  assign spi_word_o  = pwdata_i[SPI_WORD_BITS-1:0];
  assign spi_sel_o   = pwdata_i[SPI_WORD_BITS];

  ////////////////////////////////////////////////////////////////////////////
  // read mux
  ////////////////////////////////////////////////////////////////////////////

  always_comb
  begin
    prdata_o  = '0;
    pslverr_o = 1'b0;
    case (addr)
      REG_ID:       prdata_o = RP_ID;
      REG_LED:      prdata_o = APB_DW'(led_o);
      REG_EXP_DIR:  prdata_o = APB_DW'(exp_oe_o);
      REG_EXP_OUT:  prdata_o = APB_DW'(exp_o);
      REG_EXP_IN:   prdata_o = APB_DW'(exp_s2);
      REG_TAP_CNT:  prdata_o = APB_DW'({4'(tap_cnt_b0_i), 4'(tap_cnt_a0_i)});
      REG_SPI_STAT: prdata_o = {spi_busy_i, 23'd0, spi_rx_i};
      REG_TAP_RST, REG_TAP_INC, REG_TAP_DEC, REG_SPI_CMD:
        prdata_o = '0;  // write only
      default:      pslverr_o = access;  // not in the map
    endcase
  end

endmodule

/* source/rp_pkg.sv */
// shared widths, apb register map and fsm encodings; addresses are byte offsets on an 8-bit apb bus
package rp_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////////////////////

  localparam int ADC_LANES      = 7;   // lanes per converter, 2 bits per clk
  localparam int ADC_BITS       = 14;  // packed sample
  localparam int ADC_OUT_BITS   = 16;  // sample with zero lsb padding
  localparam int APB_AW         = 8;
  localparam int APB_DW         = 32;
  localparam int SPI_WORD_BITS  = 16;  // one transfer, msb first
  localparam int SPI_READ_SPLIT = 8;   // bits sent before sdio turns around
  localparam int EXP_BITS       = 9;   // expansion connector
  localparam int LED_BITS       = 8;

  localparam logic [APB_DW-1:0] RP_ID = 32'h5250_0100;  // board id

  ////////////////////////////////////////////////////////////////////////////
  // register map
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [APB_AW-1:0] {
    REG_ID       = 8'h00,  // ro
    REG_LED      = 8'h04,
    REG_EXP_DIR  = 8'h08,  // 1 drives the pin
    REG_EXP_OUT  = 8'h0C,
    REG_EXP_IN   = 8'h10,  // ro, synchronized pins
    REG_TAP_RST  = 8'h14,  // wo, lane mask pulse
    REG_TAP_INC  = 8'h18,  // wo
    REG_TAP_DEC  = 8'h1C,  // wo
    REG_TAP_CNT  = 8'h20,  // ro, {b0, a0}
    REG_SPI_CMD  = 8'h24,  // wo, {sel, word}
    REG_SPI_STAT = 8'h28   // ro, {busy, .., rx byte}
  } reg_addr_e;

  // spi master sequence
  typedef enum logic [1:0] {
    SPI_IDLE,
    SPI_LEAD,   // cs low, clk low, first bit on sdio
    SPI_SHIFT,
    SPI_TRAIL   // last falling edge before cs release
  } spi_state_e;

endpackage

/* source/rp_top.sv */
// single clk_250 domain; tap delays are whole cycles, exp pins and sdio have no tristate buffer
module rp_top
  import rp_pkg::*;
#(
  parameter int TAP_DEPTH = 8,  // max tap delay is TAP_DEPTH-1 cycles, 2..16
  parameter int SPI_DIV   = 4   // spi half period in clk_250 cycles, >= 2
)(
  input  logic                         clk_250,
  input  logic                         arst_n_i,
  // adc lanes, two bits per lane per clock
  input  logic [ADC_LANES-1:0][1:0]    adc_a_lane_i,
  input  logic [ADC_LANES-1:0][1:0]    adc_b_lane_i,
  output logic [ADC_OUT_BITS-1:0]      adc_a_o,       // carries converter b
  output logic [ADC_OUT_BITS-1:0]      adc_b_o,       // carries converter a
  // apb
  input  logic                         psel_i,
  input  logic                         penable_i,
  input  logic                         pwrite_i,
  input  logic [APB_AW-1:0]            paddr_i,
  input  logic [APB_DW-1:0]            pwdata_i,
  output logic [APB_DW-1:0]            prdata_o,
  output logic                         pready_o,
  output logic                         pslverr_o,
  // board io
  output logic [LED_BITS-1:0]          led_o,
  input  logic [EXP_BITS-1:0]          exp_i,
  output logic [EXP_BITS-1:0]          exp_o,
  output logic [EXP_BITS-1:0]          exp_oe_o,
  // 3-wire spi, cs 0 adc, cs 1 dac
  output logic [1:0]                   spi_cs_n_o,
  output logic                         spi_clk_o,
  input  logic                         spi_sdio_i,
  output logic                         spi_sdio_o,
  output logic                         spi_sdio_oe_o
);

  localparam int TAP_CW = $clog2(TAP_DEPTH);
  localparam int IDX_W  = $clog2(SPI_WORD_BITS);

  logic [2*ADC_LANES-1:0]                  tap_rst, tap_inc, tap_dec;  // lane masks
  logic [TAP_CW-1:0]                       tap_cnt_a0, tap_cnt_b0;
  logic                                    spi_start, spi_sel, spi_busy;
  logic [SPI_WORD_BITS-1:0]                spi_word;
  logic [SPI_WORD_BITS-SPI_READ_SPLIT-1:0] spi_rx;
  logic                                    tmr_run, tmr_edge_rise, tmr_edge_fall, tmr_last_bit;
  logic [IDX_W-1:0]                        bit_idx;
  logic                                    shf_load, shf_shift, shf_sample, read_mode;

  ////////////////////////////////////////////////////////////////////////////
  // adc front end
  ////////////////////////////////////////////////////////////////////////////

  adc_front #(.TAP_DEPTH (TAP_DEPTH)) i_adc_front (
    .clk_250      (clk_250),      .arst_n_i     (arst_n_i),
    .adc_a_lane_i (adc_a_lane_i), .adc_b_lane_i (adc_b_lane_i),
    .tap_rst_i    (tap_rst),      .tap_inc_i    (tap_inc),
    .tap_dec_i    (tap_dec),
    .adc_a_o      (adc_a_o),      .adc_b_o      (adc_b_o),
    .tap_cnt_a0_o (tap_cnt_a0),   .tap_cnt_b0_o (tap_cnt_b0)
  );

  ////////////////////////////////////////////////////////////////////////////
  // housekeeping
  ////////////////////////////////////////////////////////////////////////////

  hk_regs #(.TAP_DEPTH (TAP_DEPTH)) i_hk_regs (
    .clk_250      (clk_250),    .arst_n_i     (arst_n_i),
    .psel_i       (psel_i),     .penable_i    (penable_i),
    .pwrite_i     (pwrite_i),   .paddr_i      (paddr_i),
    .pwdata_i     (pwdata_i),   .prdata_o     (prdata_o),
    .pready_o     (pready_o),   .pslverr_o    (pslverr_o),
    .exp_i        (exp_i),      .led_o        (led_o),
    .exp_o        (exp_o),      .exp_oe_o     (exp_oe_o),
    .tap_cnt_a0_i (tap_cnt_a0), .tap_cnt_b0_i (tap_cnt_b0),
    .tap_rst_o    (tap_rst),    .tap_inc_o    (tap_inc),
    .tap_dec_o    (tap_dec),
    .spi_busy_i   (spi_busy),   .spi_rx_i     (spi_rx),
    .spi_start_o  (spi_start),  .spi_word_o   (spi_word),
    .spi_sel_o    (spi_sel)
  );

  ////////////////////////////////////////////////////////////////////////////
  // spi master
  ////////////////////////////////////////////////////////////////////////////

  spi_ctrl_fsm i_spi_ctrl_fsm (
    .clk_250         (clk_250),       .arst_n_i        (arst_n_i),
    .spi_start_i     (spi_start),     .spi_word_i      (spi_word),
    .spi_sel_i       (spi_sel),
    .tmr_edge_rise_i (tmr_edge_rise), .tmr_edge_fall_i (tmr_edge_fall),
    .tmr_last_bit_i  (tmr_last_bit),
    .spi_busy_o      (spi_busy),      .spi_cs_n_o      (spi_cs_n_o),
    .tmr_run_o       (tmr_run),       .shf_load_o      (shf_load),
    .shf_shift_o     (shf_shift),     .shf_sample_o    (shf_sample),
    .read_mode_o     (read_mode)
  );

  spi_bit_timer #(.SPI_DIV (SPI_DIV)) i_spi_bit_timer (
    .clk_250         (clk_250),       .arst_n_i        (arst_n_i),
    .tmr_run_i       (tmr_run),       .spi_clk_o       (spi_clk_o),
    .tmr_edge_rise_o (tmr_edge_rise), .tmr_edge_fall_o (tmr_edge_fall),
    .tmr_last_bit_o  (tmr_last_bit),  .bit_idx_o       (bit_idx)
  );

  spi_shifter i_spi_shifter (
    .clk_250       (clk_250),       .arst_n_i     (arst_n_i),
    .shf_load_i    (shf_load),      .spi_word_i   (spi_word),
    .shf_shift_i   (shf_shift),     .shf_sample_i (shf_sample),
    .read_mode_i   (read_mode),     .bit_idx_i    (bit_idx),
    .spi_sdio_i    (spi_sdio_i),    .spi_sdio_o   (spi_sdio_o),
    .spi_sdio_oe_o (spi_sdio_oe_o), .spi_rx_o     (spi_rx)
  );

endmodule

/* source/spi_bit_timer.sv */
// spi clock is clk_250 / (2 * SPI_DIV), SPI_DIV >= 2; clk held low and counters cleared while not running
module spi_bit_timer
  import rp_pkg::*;
#(
  parameter int SPI_DIV = 4
)(
  input  logic                             clk_250,
  input  logic                             arst_n_i,
  input  logic                             tmr_run_i,
  output logic                             spi_clk_o,
  output logic                             tmr_edge_rise_o,
  output logic                             tmr_edge_fall_o,
  output logic                             tmr_last_bit_o,
  output logic [$clog2(SPI_WORD_BITS)-1:0] bit_idx_o        // rising edges so far
);

  localparam int HW = $clog2(SPI_DIV);
  localparam int IW = $clog2(SPI_WORD_BITS);

  logic [HW-1:0] half_cnt;
  logic          tick;      // end of half period

  assign tick            = tmr_run_i && (half_cnt == HW'(SPI_DIV-1));
  assign tmr_edge_rise_o = tick & ~spi_clk_o;
  assign tmr_edge_fall_o = tick & spi_clk_o;
  assign tmr_last_bit_o  = tmr_edge_rise_o && (bit_idx_o == IW'(SPI_WORD_BITS-1));

  always_ff @(posedge clk_250 or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      half_cnt  <= '0;
      spi_clk_o <= 1'b0;
      bit_idx_o <= '0;
    end
    else if (!tmr_run_i)
    begin
      half_cnt  <= '0;
      spi_clk_o <= 1'b0;
      bit_idx_o <= '0;
    end
    else if (tick)
    begin
      half_cnt  <= '0;
      spi_clk_o <= ~spi_clk_o;
      if (tmr_edge_rise_o)
        bit_idx_o <= bit_idx_o + 1'b1;  // wraps to 0 after the last bit
    end
    else
      half_cnt <= half_cnt + 1'b1;
  end

endmodule

/* source/spi_ctrl_fsm.sv */
// one 16-bit transfer per start; start is ignored unless idle, so the apb side must wait on busy
module spi_ctrl_fsm
  import rp_pkg::*;
(
  input  logic                     clk_250,
  input  logic                     arst_n_i,
  input  logic                     spi_start_i,
  input  logic [SPI_WORD_BITS-1:0] spi_word_i,
  input  logic                     spi_sel_i,
  input  logic                     tmr_edge_rise_i,
  input  logic                     tmr_edge_fall_i,
  input  logic                     tmr_last_bit_i,
  output logic                     spi_busy_o,
  output logic [1:0]               spi_cs_n_o,
  output logic                     tmr_run_o,
  output logic                     shf_load_o,
  output logic                     shf_shift_o,
  output logic                     shf_sample_o,
  output logic                     read_mode_o   // word msb set
);

  spi_state_e state, state_nxt;
  logic       sel_q;  // latched target

  always_ff @(posedge clk_250 or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state       <= SPI_IDLE;
      sel_q       <= 1'b0;
      read_mode_o <= 1'b0;
    end
    else
    begin
      state <= state_nxt;
      if (shf_load_o)
      begin
        sel_q       <= spi_sel_i;
        read_mode_o <= spi_word_i[SPI_WORD_BITS-1];
      end
    end
  end

  always_comb
  begin
    state_nxt = state;
    case (state)
      SPI_IDLE:  if (spi_start_i)     state_nxt = SPI_LEAD;
      SPI_LEAD:  if (tmr_edge_rise_i) state_nxt = SPI_SHIFT;  // first rising edge
      SPI_SHIFT: if (tmr_last_bit_i)  state_nxt = SPI_TRAIL;  // 16th rising edge
      SPI_TRAIL: if (tmr_edge_fall_i) state_nxt = SPI_IDLE;   // clk back low
      default:                        state_nxt = SPI_IDLE;
    endcase
  end

  assign spi_busy_o    = (state != SPI_IDLE);
  assign tmr_run_o     = spi_busy_o;
  assign spi_cs_n_o[0] = ~(spi_busy_o & ~sel_q);  // adc
  assign spi_cs_n_o[1] = ~(spi_busy_o & sel_q);   // dac
  assign shf_load_o    = (state == SPI_IDLE) & spi_start_i;
  // sample on rise, shift on fall; trail fall lets the shifter release sdio
  assign shf_sample_o  = tmr_edge_rise_i & (state == SPI_LEAD | state == SPI_SHIFT);
  assign shf_shift_o   = tmr_edge_fall_i & (state == SPI_SHIFT | state == SPI_TRAIL);

endmodule

/* source/spi_shifter.sv */
// msb first; sdio is released after SPI_READ_SPLIT bits of a read and after the final falling edge
module spi_shifter
  import rp_pkg::*;
(
  input  logic                                    clk_250,
  input  logic                                    arst_n_i,
  input  logic                                    shf_load_i,
  input  logic [SPI_WORD_BITS-1:0]                spi_word_i,
  input  logic                                    shf_shift_i,
  input  logic                                    shf_sample_i,
  input  logic                                    read_mode_i,
  input  logic [$clog2(SPI_WORD_BITS)-1:0]        bit_idx_i,
  input  logic                                    spi_sdio_i,
  output logic                                    spi_sdio_o,
  output logic                                    spi_sdio_oe_o,
  output logic [SPI_WORD_BITS-SPI_READ_SPLIT-1:0] spi_rx_o       // last byte of a read
);

  localparam int IW = $clog2(SPI_WORD_BITS);

  logic [SPI_WORD_BITS-1:0] tx_sr;
  logic                     release_now;  // turnaround or end of word

  assign spi_sdio_o  = tx_sr[SPI_WORD_BITS-1];
  // bit_idx 0 on a fall only happens after the 16th bit wrapped it
  assign release_now = shf_shift_i &&
                       (bit_idx_i == '0 || (read_mode_i && bit_idx_i == IW'(SPI_READ_SPLIT)));

  always_ff @(posedge clk_250 or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      tx_sr         <= '0;
      spi_sdio_oe_o <= 1'b0;
      spi_rx_o      <= '0;
    end
    else
    begin
      if (shf_load_i)
        tx_sr <= spi_word_i;
      else if (shf_shift_i)
        tx_sr <= {tx_sr[SPI_WORD_BITS-2:0], 1'b0};  // next bit on falling edge

      if (shf_load_i)
        spi_sdio_oe_o <= 1'b1;
      else if (release_now)
        spi_sdio_oe_o <= 1'b0;  // slave may drive from here

      // writes leave the last read byte alone
      if (shf_sample_i && read_mode_i)
        spi_rx_o <= {spi_rx_o[SPI_WORD_BITS-SPI_READ_SPLIT-2:0], spi_sdio_i};
    end
  end

endmodule
